// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = core_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the simulation"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== src.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/host_endpoint.sv
verilog/control_unit.sv
verilog/op_fifo.sv
verilog/exec_unit.sv
verilog/core_top.sv
testbench/core_checker.sv
testbench/core_tb.sv

// ==== testbench/core_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Monitor of the AXI4-Lite write handshake, B and R channels
// and the done pulse
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

module core_checker (
    input  logic                        clock,
    input  logic                        rst_n,
    input  core_pkg::axil_req_t         axil_req,
    input  core_pkg::axil_rsp_t         axil_rsp,
    input  logic                        done,
    input  logic [`CORE_DATA_WIDTH-1:0] exp_rdata,
    input  logic [1:0]                  exp_rresp,
    input  logic [1:0]                  exp_bresp,
    output int                          data_errors,
    output int                          resp_errors,
    output int                          hold_errors,
    output int                          done_count
);

    logic                        r_beat;
    logic                        b_beat;
    logic                        r_data_bad;
    logic                        r_resp_bad;
    logic                        b_resp_bad;
    logic                        w_ready_bad;
    logic                        r_hold_bad;
    logic                        b_hold_bad;
    logic                        r_held;
    logic [`CORE_DATA_WIDTH-1:0] r_held_data;
    logic [1:0]                  r_held_resp;
    logic                        b_held;
    logic [1:0]                  b_held_resp;

    assign r_beat = axil_rsp.rvalid && axil_req.rready;
    assign b_beat = axil_rsp.bvalid && axil_req.bready;

    assign r_data_bad = r_beat && (axil_rsp.rdata !== exp_rdata);
    assign r_resp_bad = r_beat && (axil_rsp.rresp !== exp_rresp);
    assign b_resp_bad = b_beat && (axil_rsp.bresp !== exp_bresp);

    // Address and data channels are accepted together, and only with both valids
    assign w_ready_bad = (axil_rsp.awready !== axil_rsp.wready) ||
                         (axil_rsp.wready && !(axil_req.awvalid && axil_req.wvalid));

    // A response stalled by the host must come back unchanged
    assign r_hold_bad = r_held && (!axil_rsp.rvalid || (axil_rsp.rdata !== r_held_data) ||
                                   (axil_rsp.rresp !== r_held_resp));
    assign b_hold_bad = b_held && (!axil_rsp.bvalid || (axil_rsp.bresp !== b_held_resp));

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            data_errors <= 0;
            resp_errors <= 0;
            hold_errors <= 0;
            done_count  <= 0;
            r_held      <= 1'b0;
            b_held      <= 1'b0;
        end else begin
            data_errors <= data_errors + int'(r_data_bad);
            resp_errors <= resp_errors + int'(r_resp_bad) + int'(b_resp_bad) +
                           int'(w_ready_bad);
            hold_errors <= hold_errors + int'(r_hold_bad) + int'(b_hold_bad);
            done_count  <= done_count + int'(done);
            r_held      <= axil_rsp.rvalid && !axil_req.rready;
            r_held_data <= axil_rsp.rdata;
            r_held_resp <= axil_rsp.rresp;
            b_held      <= axil_rsp.bvalid && !axil_req.bready;
            b_held_resp <= axil_rsp.bresp;
        end
    end

    // Messages
    always @(posedge clock) begin
        if (rst_n && r_data_bad) begin
            $display("CHECK FAILED at time %0t: read data %08h, expected %08h",
                     $time, axil_rsp.rdata, exp_rdata);
        end
        if (rst_n && r_resp_bad) begin
            $display("CHECK FAILED at time %0t: read response %0d, expected %0d",
                     $time, axil_rsp.rresp, exp_rresp);
        end
        if (rst_n && b_resp_bad) begin
            $display("CHECK FAILED at time %0t: write response %0d, expected %0d",
                     $time, axil_rsp.bresp, exp_bresp);
        end
        if (rst_n && w_ready_bad) begin
            $display("CHECK FAILED at time %0t: awready %0b and wready %0b not raised together",
                     $time, axil_rsp.awready, axil_rsp.wready);
        end
        if (rst_n && (r_hold_bad || b_hold_bad)) begin
            $display("CHECK FAILED at time %0t: stalled response dropped or changed", $time);
        end
    end

endmodule

// ==== testbench/core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the core with host tasks, program generator,
// watchdog and register file reference model
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

module core_tb;

    import core_pkg::*;

    typedef logic [`CORE_REG_COUNT-1:0][`CORE_DATA_WIDTH-1:0] reg_image_t;

    logic                        clock;
    logic                        rst_n;
    logic                        run;
    logic                        done;
    axil_req_t                   axil_req;
    axil_rsp_t                   axil_rsp;
    logic [`CORE_DATA_WIDTH-1:0] exp_rdata;
    logic [1:0]                  exp_rresp;
    logic [1:0]                  exp_bresp;
    int                          data_errors;
    int                          resp_errors;
    int                          hold_errors;
    int                          done_count;
    int                          run_errors;
    int                          runs_started;
    int                          instr_loaded = 0;
    int                          cycle_count;
    integer                      seed;
    logic [`CORE_DATA_WIDTH-1:0] prog [`CORE_IMEM_DEPTH];
    int                          prog_len;
    reg_image_t                  model_regs;

    core_top uut (
        .clock(clock),
        .rst_n(rst_n),
        .run(run),
        .done(done),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    core_checker monitor (
        .clock(clock),
        .rst_n(rst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .done(done),
        .exp_rdata(exp_rdata),
        .exp_rresp(exp_rresp),
        .exp_bresp(exp_bresp),
        .data_errors(data_errors),
        .resp_errors(resp_errors),
        .hold_errors(hold_errors),
        .done_count(done_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Budget grows with every instruction loaded
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < 200 * instr_loaded + 2000) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Watchdog expired after %0d cycles, the core stopped making progress",
                 cycle_count);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and program generation
    //////////////////////////////////////////////////////////////////////

    function automatic reg_image_t run_model(input reg_image_t start, input int len);
        reg_image_t                  r;
        logic [`CORE_DATA_WIDTH-1:0] w;
        logic [`CORE_DATA_WIDTH-1:0] a;
        logic [`CORE_DATA_WIDTH-1:0] b;
        logic                        stopped;
        r = start;
        stopped = 1'b0;
        for (int i = 0; i < len && !stopped; i++) begin
            w = prog[i];
            a = r[w[23:20]];
            b = r[w[19:16]];
            case (w[31:28])
                ADD:     r[w[27:24]] = a + b;
                SUB:     r[w[27:24]] = a - b;
                AND:     r[w[27:24]] = a & b;
                OR:      r[w[27:24]] = a | b;
                XOR:     r[w[27:24]] = a ^ b;
                SHL:     r[w[27:24]] = a << b[4:0];
                LDI:     r[w[27:24]] = {{16{w[15]}}, w[15:0]};
                STOP:    stopped = 1'b1;
                default: ;
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] encode(input opcode_e code, input int d, input int a,
                                           input int b, input logic [15:0] imm);
        return {code, d[3:0], a[3:0], b[3:0], imm};
    endfunction

    function automatic int random_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // Kind 0 independent sums, 1 dependent logic chain, 2 random mix
    task automatic gen_program(input int len, input int kind);
        int      dest;
        int      src_a;
        int      src_b;
        int      last;
        opcode_e code;
        last = 0;
        for (int i = 0; i < len - 1; i++) begin
            dest  = random_below(16);
            src_a = random_below(16);
            src_b = random_below(16);
            case (kind)
                0: begin
                    if (i < `CORE_REG_COUNT) begin
                        dest = i;
                        prog[i] = encode(LDI, dest, 0, 0, 16'(random_below(65536)));
                    end else begin
                        if (src_a == last) begin
                            src_a = (src_a + 1) % 16;
                        end
                        if (src_b == last) begin
                            src_b = (src_b + 1) % 16;
                        end
                        code = random_below(2) ? SUB : ADD;
                        prog[i] = encode(code, dest, src_a, src_b, 16'h0);
                    end
                end
                1: begin
                    if (i < 4) begin
                        dest = i;
                        prog[i] = encode(LDI, dest, 0, 0, 16'(random_below(65536)));
                    end else begin
                        case (random_below(4))
                            0:       code = AND;
                            1:       code = OR;
                            2:       code = XOR;
                            default: code = SHL;
                        endcase
                        prog[i] = encode(code, dest, last, src_b, 16'h0);
                    end
                end
                default: begin
                    code = opcode_e'(4'(random_below(8)));
                    prog[i] = encode(code, dest, src_a, src_b, 16'(random_below(65536)));
                end
            endcase
            last = dest;
        end
        prog[len - 1] = encode(STOP, 0, 0, 0, 16'h0);
        prog_len = len;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host port tasks, entered and left 1 time unit after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] resp, input logic stall);
        int span;
        span = stall ? random_below(6) : 0;
        exp_bresp        = resp;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        do @(posedge clock); while (!axil_rsp.awready);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        repeat (span) begin
            @(posedge clock);
            #1;
        end
        axil_req.bready = 1'b1;
        do @(posedge clock); while (!axil_rsp.bvalid);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [31:0] data,
                            input logic [1:0] resp, input logic stall);
        int span;
        span = stall ? random_below(6) : 0;
        exp_rdata        = data;
        exp_rresp        = resp;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        do @(posedge clock); while (!axil_rsp.arready);
        #1;
        axil_req.arvalid = 1'b0;
        repeat (span) begin
            @(posedge clock);
            #1;
        end
        axil_req.rready = 1'b1;
        do @(posedge clock); while (!axil_rsp.rvalid);
        #1;
        axil_req.rready = 1'b0;
    endtask

    task automatic load_program(input logic stall);
        instr_loaded += prog_len;
        for (int i = 0; i < prog_len; i++) begin
            axi_write(32'(i * 4), prog[i], `CORE_RESP_OKAY, stall);
        end
    endtask

    task automatic start_run();
        run = 1'b1;
        @(posedge clock);
        #1;
        run = 1'b0;
        runs_started++;
    endtask

    task automatic wait_run_done();
        do @(posedge clock); while (done_count < runs_started);
        #1;
    endtask

    task automatic read_registers(input logic stall);
        for (int r = 0; r < `CORE_REG_COUNT; r++) begin
            axi_read(`CORE_REG_BASE + 32'(r * 4), model_regs[r], `CORE_RESP_OKAY, stall);
        end
    endtask

    task automatic check_done_count();
        if (done_count != runs_started) begin
            run_errors++;
            $display("CHECK FAILED at time %0t: %0d done pulses after %0d runs",
                     $time, done_count, runs_started);
        end
    endtask

    task automatic run_program(input logic stall);
        load_program(stall);
        model_regs = run_model(model_regs, prog_len);
        start_run();
        wait_run_done();
        read_registers(stall);
        check_done_count();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        seed         = 32'h50e6;
        rst_n        = 1'b0;
        run          = 1'b0;
        axil_req     = '0;
        exp_rdata    = '0;
        exp_rresp    = `CORE_RESP_OKAY;
        exp_bresp    = `CORE_RESP_OKAY;
        run_errors   = 0;
        runs_started = 0;
        model_regs   = '0;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(posedge clock);
        #1;

        // Arithmetic, then dependent logic chains
        gen_program(40, 0);
        run_program(1'b0);
        gen_program(48, 1);
        run_program(1'b0);

        // Error responses, including a write while the core runs
        axi_read(32'h0000_0010, 32'h0, `CORE_RESP_SLVERR, 1'b0);
        axi_write(`CORE_REG_BASE + 32'h8, 32'hdead_beef, `CORE_RESP_SLVERR, 1'b0);
        gen_program(40, 2);
        load_program(1'b0);
        model_regs = run_model(model_regs, prog_len);
        start_run();
        axi_write(32'h0000_0014, encode(LDI, 0, 0, 0, 16'h7777), `CORE_RESP_SLVERR, 1'b0);
        wait_run_done();
        read_registers(1'b0);
        check_done_count();

        // Host back-pressure on B and R
        gen_program(32, 2);
        run_program(1'b1);

        // Back to back runs, registers carry over
        for (int n = 0; n < 5; n++) begin
            gen_program(20 + random_below(41), 2);
            run_program(n[0]);
        end

        $display("Errors: data %0d, response %0d, hold %0d, run %0d",
                 data_errors, resp_errors, hold_errors, run_errors);
        if (data_errors + resp_errors + hold_errors + run_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/control_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction store, program counter, fetch FSM and decoder
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

module control_unit (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic                  done,
    input  core_pkg::imem_write_t imem_write,
    output logic                  busy,
    output core_pkg::op_t         op,
    output logic                  op_valid,
    input  logic                  op_ready
);

    import core_pkg::*;

    logic [`CORE_DATA_WIDTH-1:0]      imem [`CORE_IMEM_DEPTH];
    logic [`CORE_DATA_WIDTH-1:0]      word;
    logic [`CORE_IMEM_ADDR_WIDTH-1:0] pc;
    fetch_state_e                     state;
    logic                             advance;
    logic                             push_stop;

    // Program load from the host port
    always_ff @(posedge clock) begin
        if (imem_write.valid) begin
            imem[imem_write.addr] <= imem_write.data;
        end
    end

    // Output register is free or drains this cycle
    assign advance   = !op_valid || op_ready;
    assign push_stop = op_valid && op_ready && (op.opcode == STOP);

    //////////////////////////////////////////////////////////////////////
    // Fetch FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            pc       <= '0;
            busy     <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        state <= FETCH;
                        pc    <= '0;
                        busy  <= 1'b1;
                    end
                end
                FETCH: begin
                    // Nothing past STOP is offered
                    if (push_stop) begin
                        state    <= WAIT_DONE;
                        op_valid <= 1'b0;
                    end else if (advance) begin
                        op_valid <= 1'b1;
                        pc       <= pc + 1'b1;
                    end
                end
                WAIT_DONE: begin
                    if (done) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Synchronous store read, held while the FIFO is full
    always_ff @(posedge clock) begin
        if (state == FETCH && advance && !push_stop) begin
            word <= imem[pc];
        end
    end

    // Decode
    always_comb begin
        op.opcode = opcode_e'(word[31:28]);
        op.dest   = word[27:24];
        op.src_a  = word[23:20];
        op.src_b  = word[19:16];
        op.imm    = word[15:0];
    end

    op_stable: assert property (@(posedge clock) disable iff (!rst_n)
        op_valid && !op_ready |=> op_valid && $stable(op));

endmodule

// ==== verilog/core_params.svh ====
//////////////////////////////////////////////////////////////////////
// Widths, depths, AXI4-Lite response codes and the host address map
//////////////////////////////////////////////////////////////////////

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and storage sizes
`define CORE_DATA_WIDTH      32
`define CORE_IMEM_DEPTH      256
`define CORE_IMEM_ADDR_WIDTH 8
`define CORE_REG_COUNT       16
`define CORE_REG_ADDR_WIDTH  4
`define CORE_FIFO_DEPTH      4

// Host port
`define CORE_AXI_ADDR_WIDTH  32
`define CORE_REG_BASE        32'h1000
`define CORE_RESP_OKAY       2'b00
`define CORE_RESP_SLVERR     2'b10

`endif

// ==== verilog/core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Opcode and fetch state enums, operation and AXI4-Lite structs
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

package core_pkg;

    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        OR   = 4'h4,
        XOR  = 4'h5,
        SHL  = 4'h6,
        LDI  = 4'h7,
        STOP = 4'h8
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WAIT_DONE
    } fetch_state_e;

    // Same bit layout as an instruction word
    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  dest;
        logic [3:0]  src_a;
        logic [3:0]  src_b;
        logic [15:0] imm;
    } op_t;

    // Master driven side of the host port
    typedef struct packed {
        logic [`CORE_AXI_ADDR_WIDTH-1:0] awaddr;
        logic                            awvalid;
        logic [`CORE_DATA_WIDTH-1:0]     wdata;
        logic [`CORE_DATA_WIDTH/8-1:0]   wstrb;
        logic                            wvalid;
        logic                            bready;
        logic [`CORE_AXI_ADDR_WIDTH-1:0] araddr;
        logic                            arvalid;
        logic                            rready;
    } axil_req_t;

    // Slave driven side of the host port
    typedef struct packed {
        logic                        awready;
        logic                        wready;
        logic [1:0]                  bresp;
        logic                        bvalid;
        logic                        arready;
        logic [`CORE_DATA_WIDTH-1:0] rdata;
        logic [1:0]                  rresp;
        logic                        rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic                             valid;
        logic [`CORE_IMEM_ADDR_WIDTH-1:0] addr;
        logic [`CORE_DATA_WIDTH-1:0]      data;
    } imem_write_t;

endpackage

// ==== verilog/core_top.sv ====
//////////////////////////////////////////////////////////////////////
// Core top level with host port, fetch, operation FIFO and executor
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

module core_top (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                run,
    output logic                done,
    input  core_pkg::axil_req_t axil_req,
    output core_pkg::axil_rsp_t axil_rsp
);

    import core_pkg::*;

    logic                            busy;
    imem_write_t                     imem_write;
    logic [`CORE_REG_ADDR_WIDTH-1:0] reg_read_addr;
    logic [`CORE_DATA_WIDTH-1:0]     reg_read_data;

    // Control unit to FIFO
    op_t  fetch_op;
    logic fetch_valid;
    logic fetch_ready;

    // FIFO to executor
    op_t  issue_op;
    logic issue_valid;
    logic issue_ready;

    host_endpoint endpoint (
        .clock(clock),
        .rst_n(rst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .busy(busy),
        .imem_write(imem_write),
        .reg_read_addr(reg_read_addr),
        .reg_read_data(reg_read_data)
    );

    control_unit control (
        .clock(clock),
        .rst_n(rst_n),
        .run(run),
        .done(done),
        .imem_write(imem_write),
        .busy(busy),
        .op(fetch_op),
        .op_valid(fetch_valid),
        .op_ready(fetch_ready)
    );

    op_fifo #(
        .DEPTH(`CORE_FIFO_DEPTH)
    ) fifo (
        .clock(clock),
        .rst_n(rst_n),
        .in_op(fetch_op),
        .in_valid(fetch_valid),
        .in_ready(fetch_ready),
        .out_op(issue_op),
        .out_valid(issue_valid),
        .out_ready(issue_ready)
    );

    exec_unit executor (
        .clock(clock),
        .rst_n(rst_n),
        .op(issue_op),
        .op_valid(issue_valid),
        .op_ready(issue_ready),
        .done(done),
        .reg_read_addr(reg_read_addr),
        .reg_read_data(reg_read_data)
    );

endmodule

// ==== verilog/exec_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Two-stage executor with register file, ALU and hazard stall
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

module exec_unit (
    input  logic                            clock,
    input  logic                            rst_n,
    input  core_pkg::op_t                   op,
    input  logic                            op_valid,
    output logic                            op_ready,
    output logic                            done,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] reg_read_addr,
    output logic [`CORE_DATA_WIDTH-1:0]     reg_read_data
);

    import core_pkg::*;

    logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_REG_COUNT];
    op_t                         ex_op;
    logic                        ex_valid;
    logic [`CORE_DATA_WIDTH-1:0] ex_a;
    logic [`CORE_DATA_WIDTH-1:0] ex_b;
    logic [`CORE_DATA_WIDTH-1:0] result;
    logic                        ex_writes;
    logic                        hazard;
    logic                        accept;

    function automatic logic reads_regs(input opcode_e code);
        return code inside {ADD, SUB, AND, OR, XOR, SHL};
    endfunction

    function automatic logic writes_reg(input opcode_e code);
        return reads_regs(code) || (code == LDI);
    endfunction

    // Stage two writes on the same edge that stage one samples operands,
    // so a reader of that destination waits one cycle
    assign ex_writes = ex_valid && writes_reg(ex_op.opcode);
    assign hazard    = op_valid && ex_writes && reads_regs(op.opcode) &&
                       ((op.src_a == ex_op.dest) || (op.src_b == ex_op.dest));
    assign op_ready  = !hazard;
    assign accept    = op_valid && op_ready;

    //////////////////////////////////////////////////////////////////////
    // Stage one: operand read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ex_op <= op;
            ex_a  <= regs[op.src_a];
            ex_b  <= regs[op.src_b];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage two: ALU and writeback
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ex_op.opcode)
            ADD:     result = ex_a + ex_b;
            SUB:     result = ex_a - ex_b;
            AND:     result = ex_a & ex_b;
            OR:      result = ex_a | ex_b;
            XOR:     result = ex_a ^ ex_b;
            SHL:     result = ex_a << ex_b[4:0];
            LDI:     result = {{(`CORE_DATA_WIDTH-16){ex_op.imm[15]}}, ex_op.imm};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_writes) begin
            regs[ex_op.dest] <= result;
        end
    end

    // STOP in stage two means every earlier write has landed
    assign done = ex_valid && (ex_op.opcode == STOP);

    // Host readback port
    assign reg_read_data = regs[reg_read_addr];

    // Fetch stops after STOP, so done never repeats back to back
    done_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        done |=> !done);

endmodule

// ==== verilog/host_endpoint.sv ====
//////////////////////////////////////////////////////////////////////
// AXI4-Lite slave for program load and register file readback
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

module host_endpoint (
    input  logic                              clock,
    input  logic                              rst_n,
    input  core_pkg::axil_req_t               axil_req,
    output core_pkg::axil_rsp_t               axil_rsp,
    input  logic                              busy,
    output core_pkg::imem_write_t             imem_write,
    output logic [`CORE_REG_ADDR_WIDTH-1:0]   reg_read_addr,
    input  logic [`CORE_DATA_WIDTH-1:0]       reg_read_data
);

    logic                             write_fire;
    logic                             read_fire;
    logic                             write_ok;
    logic                             ar_is_reg;
    logic                             bvalid;
    logic [1:0]                       bresp;
    logic                             rvalid;
    logic [1:0]                       rresp;
    logic [`CORE_DATA_WIDTH-1:0]      rdata;
    logic                             imem_valid;
    logic [`CORE_IMEM_ADDR_WIDTH-1:0] imem_addr;
    logic [`CORE_DATA_WIDTH-1:0]      imem_data;

    // Address and data must arrive together, one response outstanding at a time
    assign write_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign read_fire  = axil_req.arvalid && !rvalid;

    // Program space is writable only while the core is idle
    assign write_ok  = (axil_req.awaddr < `CORE_REG_BASE) && !busy;
    assign ar_is_reg = axil_req.araddr >= `CORE_REG_BASE;

    assign reg_read_addr = axil_req.araddr[`CORE_REG_ADDR_WIDTH+1:2];

    //////////////////////////////////////////////////////////////////////
    // Response handshakes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            imem_valid <= 1'b0;
        end else begin
            if (write_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
            imem_valid <= write_fire && write_ok;
        end
    end

    // Payloads load only on an accepted request
    always_ff @(posedge clock) begin
        if (write_fire) begin
            bresp     <= write_ok ? `CORE_RESP_OKAY : `CORE_RESP_SLVERR;
            imem_addr <= axil_req.awaddr[`CORE_IMEM_ADDR_WIDTH+1:2];
            imem_data <= axil_req.wdata;
        end
        if (read_fire) begin
            rresp <= ar_is_reg ? `CORE_RESP_OKAY : `CORE_RESP_SLVERR;
            rdata <= ar_is_reg ? reg_read_data : '0;
        end
    end

    assign imem_write = '{valid: imem_valid, addr: imem_addr, data: imem_data};

    always_comb begin
        axil_rsp.awready = write_fire;
        axil_rsp.wready  = write_fire;
        axil_rsp.bresp   = bresp;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = read_fire;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
        axil_rsp.rvalid  = rvalid;
    end

    bvalid_held: assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && !axil_req.bready |=> bvalid && $stable(bresp));

    rdata_held: assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && !axil_req.rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== verilog/op_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// Circular FIFO of decoded operations, valid/ready on both sides
//////////////////////////////////////////////////////////////////////

`include "core_params.svh"

module op_fifo #(
    parameter int DEPTH = `CORE_FIFO_DEPTH
) (
    input  logic          clock,
    input  logic          rst_n,
    input  core_pkg::op_t in_op,
    input  logic          in_valid,
    output logic          in_ready,
    output core_pkg::op_t out_op,
    output logic          out_valid,
    input  logic          out_ready
);

    import core_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    op_t              mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign in_ready  = count != CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_op    = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_op;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Count is unchanged when both sides move
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    count_bound: assert property (@(posedge clock) disable iff (!rst_n)
        count <= CNT_W'(DEPTH));

endmodule
